// ==== source/hub75_pkg.sv ====
// shared package for the HUB75 driver
// default geometry, pixel type, command opcodes, fixed latencies
package hub75_pkg;

    // defaults picked up by the top level
    localparam int DEFAULT_PANEL_WIDTH        = 16;
    localparam int DEFAULT_PANEL_HALFHEIGHT   = 4;  // also number of row addresses
    localparam int DEFAULT_UART_TICKS_PER_BIT = 8;
    localparam int DEFAULT_PLANE_BASE_TICKS   = 4;  // display cycles of plane 0

    // bits per colour channel, one bit plane each
    localparam int BRIGHTNESS_BITS = 4;

    typedef struct packed {
        logic [BRIGHTNESS_BITS-1:0] red;
        logic [BRIGHTNESS_BITS-1:0] green;
        logic [BRIGHTNESS_BITS-1:0] blue;
    } pixel_t;

    // command opcodes on the serial line
    localparam logic [7:0] CMD_PIXEL        = 8'h50;  // 'P' + col, row, r, g, b
    localparam logic [7:0] CMD_BRIGHTNESS   = 8'h42;  // 'B' + plane mask
    localparam logic [7:0] CMD_COLOR_ENABLE = 8'h45;  // 'E' + rgb enable bits

    // load pulse to valid rgb bits
    localparam int FETCH_LATENCY = 2;

endpackage

// ==== source/uart_rx.sv ====
// 8N1 serial receiver
// two-flop line synchronizer, mid-bit sampling, stop bit check
`timescale 1ns/1ps

module uart_rx #(
    parameter int UART_TICKS_PER_BIT = hub75_pkg::DEFAULT_UART_TICKS_PER_BIT
) (
    input  logic       clk_root,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    localparam int CNT_W = $clog2(UART_TICKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(UART_TICKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(UART_TICKS_PER_BIT - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    logic [1:0]       sync_q;
    logic             rx_line;
    logic [CNT_W-1:0] tick_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;

    assign rx_line = sync_q[1];
    assign rx_data = shift_q;  // stable until the next frame's data bits

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            sync_q   <= 2'b11;  // idle line is high
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            shift_q  <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync_q   <= {sync_q[0], rx};
            rx_valid <= 1'b0;
            tick_cnt <= tick_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_line) state <= RX_START;
                end
                RX_START: if (tick_cnt == HALF_LAST) begin  // middle of start bit
                    tick_cnt <= '0;
                    bit_idx  <= '0;
                    state    <= rx_line ? RX_IDLE : RX_DATA;  // glitch, back to idle
                end
                RX_DATA: if (tick_cnt == BIT_LAST) begin
                    tick_cnt <= '0;
                    shift_q  <= {rx_line, shift_q[7:1]};  // lsb first
                    bit_idx  <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (tick_cnt == BIT_LAST) begin
                    rx_valid <= rx_line;  // bad stop bit drops the frame
                    state    <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// ==== source/command_decoder.sv ====
// command byte parser
// pixel writes into the top or bottom frame RAM, brightness and colour enables
`timescale 1ns/1ps

module command_decoder #(
    parameter int PANEL_WIDTH      = hub75_pkg::DEFAULT_PANEL_WIDTH,
    parameter int PANEL_HALFHEIGHT = hub75_pkg::DEFAULT_PANEL_HALFHEIGHT
) (
    input  logic                                  clk_root,
    input  logic                                  rst_n,
    input  logic [7:0]                            rx_data,
    input  logic                                  rx_valid,
    output logic                                  wr_en_top,
    output logic                                  wr_en_bottom,
    output logic [$clog2(PANEL_WIDTH*PANEL_HALFHEIGHT)-1:0] wr_addr,
    output hub75_pkg::pixel_t                     wr_pixel,
    output logic [hub75_pkg::BRIGHTNESS_BITS-1:0] brightness_enable,
    output logic [2:0]                            rgb_enable
);

    import hub75_pkg::*;

    localparam int ADDR_W = $clog2(PANEL_WIDTH * PANEL_HALFHEIGHT);
    localparam int COL_W  = $clog2(PANEL_WIDTH);
    localparam int ROW_W  = $clog2(PANEL_HALFHEIGHT) + 1;  // msb picks the half

    typedef enum logic [1:0] {DEC_IDLE, DEC_PIXEL, DEC_BRIGHT, DEC_COLOR} dec_state_t;

    dec_state_t                 state;
    logic [2:0]                 arg_cnt;  // operand index within a pixel command
    logic [COL_W-1:0]           col_q;
    logic [ROW_W-1:0]           row_q;
    logic [BRIGHTNESS_BITS-1:0] red_q;
    logic [BRIGHTNESS_BITS-1:0] green_q;

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state             <= DEC_IDLE;
            arg_cnt           <= '0;
            wr_en_top         <= 1'b0;
            wr_en_bottom      <= 1'b0;
            brightness_enable <= '1;
            rgb_enable        <= '1;
        end else begin
            wr_en_top    <= 1'b0;
            wr_en_bottom <= 1'b0;
            if (rx_valid) begin
                case (state)
                    DEC_IDLE: begin
                        arg_cnt <= '0;
                        case (rx_data)
                            CMD_PIXEL:        state <= DEC_PIXEL;
                            CMD_BRIGHTNESS:   state <= DEC_BRIGHT;
                            CMD_COLOR_ENABLE: state <= DEC_COLOR;
                            default:          state <= DEC_IDLE;  // stray byte
                        endcase
                    end
                    DEC_PIXEL: begin
                        arg_cnt <= arg_cnt + 1'b1;
                        if (arg_cnt == 3'd4) begin  // blue byte, write next cycle
                            wr_en_top    <= ~row_q[ROW_W-1];
                            wr_en_bottom <= row_q[ROW_W-1];
                            state        <= DEC_IDLE;
                        end
                    end
                    DEC_BRIGHT: begin
                        brightness_enable <= rx_data[BRIGHTNESS_BITS-1:0];
                        state             <= DEC_IDLE;
                    end
                    default: begin
                        rgb_enable <= rx_data[2:0];
                        state      <= DEC_IDLE;
                    end
                endcase
            end
        end
    end

    // operand capture
    always_ff @(posedge clk_root) begin
        if (rx_valid && state == DEC_PIXEL) begin
            case (arg_cnt)
                3'd0: col_q   <= rx_data[COL_W-1:0];
                3'd1: row_q   <= rx_data[ROW_W-1:0];
                3'd2: red_q   <= rx_data[BRIGHTNESS_BITS-1:0];
                3'd3: green_q <= rx_data[BRIGHTNESS_BITS-1:0];
                default: begin
                    wr_addr        <= ADDR_W'(row_q[ROW_W-2:0] * PANEL_WIDTH + col_q);
                    wr_pixel.red   <= red_q;
                    wr_pixel.green <= green_q;
                    wr_pixel.blue  <= rx_data[BRIGHTNESS_BITS-1:0];
                end
            endcase
        end
    end

endmodule

// ==== source/frame_ram.sv ====
// pixel RAM for one half of the panel
// one write port, one read port with registered output
`timescale 1ns/1ps

module frame_ram #(
    parameter int DEPTH = hub75_pkg::DEFAULT_PANEL_WIDTH * hub75_pkg::DEFAULT_PANEL_HALFHEIGHT
) (
    input  logic                     clk_root,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  hub75_pkg::pixel_t        wr_pixel,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output hub75_pkg::pixel_t        rd_pixel
);

    import hub75_pkg::*;

    pixel_t mem [DEPTH];

    always_ff @(posedge clk_root) begin
        if (wr_en) mem[wr_addr] <= wr_pixel;
        rd_pixel <= mem[rd_addr];  // one cycle read
    end

endmodule

// ==== source/scan_timer.sv ====
// panel scan sequencer
// column loads, row latch, binary-weighted display time per bit plane
`timescale 1ns/1ps

module scan_timer #(
    parameter int PANEL_WIDTH      = hub75_pkg::DEFAULT_PANEL_WIDTH,
    parameter int PANEL_HALFHEIGHT = hub75_pkg::DEFAULT_PANEL_HALFHEIGHT,
    parameter int PLANE_BASE_TICKS = hub75_pkg::DEFAULT_PLANE_BASE_TICKS
) (
    input  logic                                          clk_root,
    input  logic                                          rst_n,
    output logic                                          load,
    output logic [$clog2(PANEL_WIDTH)-1:0]                column,
    output logic [$clog2(PANEL_HALFHEIGHT)-1:0]           row,
    output logic [$clog2(hub75_pkg::BRIGHTNESS_BITS)-1:0] plane,
    output logic                                          clk_pixel,
    output logic                                          row_latch,
    output logic                                          oe_n,
    output logic [$clog2(PANEL_HALFHEIGHT)-1:0]           row_address
);

    import hub75_pkg::*;

    localparam int COL_W        = $clog2(PANEL_WIDTH);
    localparam int SHIFT_CYCLES = 2 * PANEL_WIDTH + 2;  // loads plus fetch drain
    localparam int MAX_DISPLAY  = PLANE_BASE_TICKS << (BRIGHTNESS_BITS - 1);
    localparam int TICK_W       = $clog2(SHIFT_CYCLES > MAX_DISPLAY ? SHIFT_CYCLES : MAX_DISPLAY);

    typedef enum logic [1:0] {ST_SHIFT, ST_LATCH, ST_DISPLAY} scan_state_t;

    scan_state_t              state;
    logic [TICK_W-1:0]        tick;
    logic [FETCH_LATENCY-1:0] pix_dly;  // aligns clk_pixel with fetched bits

    assign load      = (state == ST_SHIFT) && !tick[0] && (tick < TICK_W'(2 * PANEL_WIDTH));
    assign column    = tick[COL_W:1];
    assign clk_pixel = pix_dly[FETCH_LATENCY-1];
    assign row_latch = (state == ST_LATCH);
    assign oe_n      = (state != ST_DISPLAY);

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_SHIFT;
            tick        <= '0;
            pix_dly     <= '0;
            row         <= '0;
            plane       <= '0;
            row_address <= '0;
        end else begin
            pix_dly <= {pix_dly[FETCH_LATENCY-2:0], load};
            tick    <= tick + 1'b1;
            case (state)
                ST_SHIFT: if (tick == TICK_W'(SHIFT_CYCLES - 1)) begin
                    state       <= ST_LATCH;
                    row_address <= row;  // panel takes the row with the latch
                end
                ST_LATCH: begin
                    tick  <= '0;
                    state <= ST_DISPLAY;
                end
                default: if (tick == TICK_W'((PLANE_BASE_TICKS << plane) - 1)) begin
                    tick  <= '0;
                    state <= ST_SHIFT;
                    if (plane == $bits(plane)'(BRIGHTNESS_BITS - 1)) begin
                        plane <= '0;
                        row   <= (row == $bits(row)'(PANEL_HALFHEIGHT - 1)) ? '0 : row + 1'b1;
                    end else begin
                        plane <= plane + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== source/framebuffer_fetch.sv ====
// two-stage pixel fetch
// RAM read for both halves, then bit-plane select with brightness and colour enables
`timescale 1ns/1ps

module framebuffer_fetch #(
    parameter int PANEL_WIDTH      = hub75_pkg::DEFAULT_PANEL_WIDTH,
    parameter int PANEL_HALFHEIGHT = hub75_pkg::DEFAULT_PANEL_HALFHEIGHT
) (
    input  logic                                          clk_root,
    input  logic                                          rst_n,
    input  logic                                          load,
    input  logic [$clog2(PANEL_WIDTH)-1:0]                column,
    input  logic [$clog2(PANEL_HALFHEIGHT)-1:0]           row,
    input  logic [$clog2(hub75_pkg::BRIGHTNESS_BITS)-1:0] plane,
    input  logic [hub75_pkg::BRIGHTNESS_BITS-1:0]         brightness_enable,
    input  logic [2:0]                                    rgb_enable,
    output logic [$clog2(PANEL_WIDTH*PANEL_HALFHEIGHT)-1:0] rd_addr,
    input  hub75_pkg::pixel_t                             rd_pixel_top,
    input  hub75_pkg::pixel_t                             rd_pixel_bottom,
    output logic [2:0]                                    rgb_top,
    output logic [2:0]                                    rgb_bottom
);

    import hub75_pkg::*;

    localparam int ADDR_W  = $clog2(PANEL_WIDTH * PANEL_HALFHEIGHT);
    localparam int PLANE_W = $clog2(BRIGHTNESS_BITS);

    logic               load_q;
    logic [PLANE_W-1:0] plane_q;

    // bit p of each channel, gated by both enables; bit 0 is red
    function automatic logic [2:0] plane_bits(input pixel_t px, input logic [PLANE_W-1:0] p);
        logic [2:0] bits;
        bits = {px.blue[p], px.green[p], px.red[p]};
        return bits & rgb_enable & {3{brightness_enable[p]}};
    endfunction

    // stage 1, same address into both halves
    assign rd_addr = ADDR_W'(row * PANEL_WIDTH + column);

    always_ff @(posedge clk_root) begin
        plane_q <= plane;
    end

    always_ff @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            load_q     <= 1'b0;
            rgb_top    <= '0;
            rgb_bottom <= '0;
        end else begin
            load_q <= load;
            if (load_q) begin  // stage 2, RAM data is valid now
                rgb_top    <= plane_bits(rd_pixel_top, plane_q);
                rgb_bottom <= plane_bits(rd_pixel_bottom, plane_q);
            end
        end
    end

endmodule

// ==== source/hub75_top.sv ====
// HUB75 panel driver top level
// uart_rx -> command_decoder -> frame RAMs -> framebuffer_fetch, paced by scan_timer
`timescale 1ns/1ps

module hub75_top #(
    parameter int PANEL_WIDTH        = hub75_pkg::DEFAULT_PANEL_WIDTH,
    parameter int PANEL_HALFHEIGHT   = hub75_pkg::DEFAULT_PANEL_HALFHEIGHT,
    parameter int UART_TICKS_PER_BIT = hub75_pkg::DEFAULT_UART_TICKS_PER_BIT,
    parameter int PLANE_BASE_TICKS   = hub75_pkg::DEFAULT_PLANE_BASE_TICKS
) (
    input  logic                                clk_root,
    input  logic                                rst_n,
    input  logic                                rx,
    output logic [2:0]                          rgb_top,
    output logic [2:0]                          rgb_bottom,
    output logic [$clog2(PANEL_HALFHEIGHT)-1:0] row_address,
    output logic                                clk_pixel,
    output logic                                row_latch,
    output logic                                oe_n
);

    import hub75_pkg::*;

    localparam int DEPTH = PANEL_WIDTH * PANEL_HALFHEIGHT;

    logic [7:0]                          rx_data;
    logic                                rx_valid;
    logic                                wr_en_top;
    logic                                wr_en_bottom;
    logic [$clog2(DEPTH)-1:0]            wr_addr;
    pixel_t                              wr_pixel;
    logic [BRIGHTNESS_BITS-1:0]          brightness_enable;
    logic [2:0]                          rgb_enable;
    logic [$clog2(DEPTH)-1:0]            rd_addr;
    pixel_t                              rd_pixel_top;
    pixel_t                              rd_pixel_bottom;
    logic                                load;
    logic [$clog2(PANEL_WIDTH)-1:0]      column;
    logic [$clog2(PANEL_HALFHEIGHT)-1:0] row;
    logic [$clog2(BRIGHTNESS_BITS)-1:0]  plane;

    uart_rx #(
        .UART_TICKS_PER_BIT(UART_TICKS_PER_BIT)
    ) u_uart_rx (
        .clk_root(clk_root), .rst_n(rst_n), .rx(rx),
        .rx_data(rx_data), .rx_valid(rx_valid)
    );

    command_decoder #(
        .PANEL_WIDTH(PANEL_WIDTH),
        .PANEL_HALFHEIGHT(PANEL_HALFHEIGHT)
    ) u_decoder (
        .clk_root(clk_root), .rst_n(rst_n),
        .rx_data(rx_data), .rx_valid(rx_valid),
        .wr_en_top(wr_en_top), .wr_en_bottom(wr_en_bottom),
        .wr_addr(wr_addr), .wr_pixel(wr_pixel),
        .brightness_enable(brightness_enable), .rgb_enable(rgb_enable)
    );

    // rows 0 .. half-1
    frame_ram #(.DEPTH(DEPTH)) u_ram_top (
        .clk_root(clk_root), .wr_en(wr_en_top), .wr_addr(wr_addr), .wr_pixel(wr_pixel),
        .rd_addr(rd_addr), .rd_pixel(rd_pixel_top)
    );

    frame_ram #(.DEPTH(DEPTH)) u_ram_bottom (  // rows half .. 2*half-1
        .clk_root(clk_root), .wr_en(wr_en_bottom), .wr_addr(wr_addr), .wr_pixel(wr_pixel),
        .rd_addr(rd_addr), .rd_pixel(rd_pixel_bottom)
    );

    scan_timer #(
        .PANEL_WIDTH(PANEL_WIDTH),
        .PANEL_HALFHEIGHT(PANEL_HALFHEIGHT),
        .PLANE_BASE_TICKS(PLANE_BASE_TICKS)
    ) u_scan (
        .clk_root(clk_root), .rst_n(rst_n),
        .load(load), .column(column), .row(row), .plane(plane),
        .clk_pixel(clk_pixel), .row_latch(row_latch), .oe_n(oe_n),
        .row_address(row_address)
    );

    framebuffer_fetch #(
        .PANEL_WIDTH(PANEL_WIDTH),
        .PANEL_HALFHEIGHT(PANEL_HALFHEIGHT)
    ) u_fetch (
        .clk_root(clk_root), .rst_n(rst_n),
        .load(load), .column(column), .row(row), .plane(plane),
        .brightness_enable(brightness_enable), .rgb_enable(rgb_enable),
        .rd_addr(rd_addr), .rd_pixel_top(rd_pixel_top), .rd_pixel_bottom(rd_pixel_bottom),
        .rgb_top(rgb_top), .rgb_bottom(rgb_bottom)
    );

endmodule

// ==== verification/hub75_chk.sv ====
// bound checker on the HUB75 panel pins
// reset state, shift count, blanking, display time and row order
`timescale 1ns/1ps

module hub75_chk #(
    parameter int PANEL_WIDTH      = hub75_pkg::DEFAULT_PANEL_WIDTH,
    parameter int PANEL_HALFHEIGHT = hub75_pkg::DEFAULT_PANEL_HALFHEIGHT,
    parameter int PLANE_BASE_TICKS = hub75_pkg::DEFAULT_PLANE_BASE_TICKS
) (
    input logic                                clk_root,
    input logic                                rst_n,
    input logic [$clog2(PANEL_HALFHEIGHT)-1:0] row_address,
    input logic                                clk_pixel,
    input logic                                row_latch,
    input logic                                oe_n
);

    import hub75_pkg::*;

    int   fail_count = 0;
    logic started    = 1'b0;  // first edge seen, outputs are out of X
    int   pix_cnt;            // clk_pixel pulses since the last latch
    int   step_cnt;           // latches since reset
    int   low_len;
    int   window_cnt;         // completed display windows
    int   exp_plane;
    int   exp_row;

    assign exp_plane = window_cnt % BRIGHTNESS_BITS;
    assign exp_row   = (step_cnt / BRIGHTNESS_BITS) % PANEL_HALFHEIGHT;

    always @(posedge clk_root) begin
        started <= 1'b1;
    end

    always @(posedge clk_root or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt    <= 0;
            step_cnt   <= 0;
            low_len    <= 0;
            window_cnt <= 0;
        end else begin
            if (row_latch) begin
                pix_cnt  <= 0;
                step_cnt <= step_cnt + 1;
            end else if (clk_pixel) begin
                pix_cnt <= pix_cnt + 1;
            end
            if (!oe_n) begin
                low_len <= low_len + 1;
            end else begin
                low_len <= 0;
                if (low_len != 0) window_cnt <= window_cnt + 1;  // window just closed
            end
        end
    end

    a_reset_state: assert property (@(posedge clk_root)
        started && (!rst_n || !$past(rst_n)) |->
            oe_n && !row_latch && !clk_pixel && row_address == '0)
    else begin
        $error("panel outputs are not in their reset state around reset");
        fail_count++;
    end

    a_shift_count: assert property (@(posedge clk_root) disable iff (!rst_n)
        row_latch |-> pix_cnt == PANEL_WIDTH)
    else begin
        $error("[ERROR] %0t pix_cnt expected %0d actual %0d",
               $time, PANEL_WIDTH, $sampled(pix_cnt));
        fail_count++;
    end

    a_blanking: assert property (@(posedge clk_root) disable iff (!rst_n)
        (clk_pixel || row_latch) |-> oe_n)
    else begin
        $error("oe_n is low while clk_pixel or row_latch is high");
        fail_count++;
    end

    a_display_time: assert property (@(posedge clk_root) disable iff (!rst_n)
        (oe_n && low_len != 0) |-> low_len == (PLANE_BASE_TICKS << exp_plane))
    else begin
        $error("[ERROR] %0t oe_n low cycles expected %0d actual %0d",
               $time, PLANE_BASE_TICKS << $sampled(exp_plane), $sampled(low_len));
        fail_count++;
    end

    a_row_order: assert property (@(posedge clk_root) disable iff (!rst_n)
        row_latch |-> row_address == exp_row)
    else begin
        $error("[ERROR] %0t row_address expected %0d actual %0d",
               $time, $sampled(exp_row), $sampled(row_address));
        fail_count++;
    end

endmodule

bind hub75_top hub75_chk #(
    .PANEL_WIDTH(PANEL_WIDTH),
    .PANEL_HALFHEIGHT(PANEL_HALFHEIGHT),
    .PLANE_BASE_TICKS(PLANE_BASE_TICKS)
) u_chk (
    .clk_root(clk_root),
    .rst_n(rst_n),
    .row_address(row_address),
    .clk_pixel(clk_pixel),
    .row_latch(row_latch),
    .oe_n(oe_n)
);

// ==== verification/tb_hub75.sv ====
// testbench for the HUB75 panel driver
// UART commands, shadow framebuffer, pixel checks at each clk_pixel
`timescale 1ns/1ps

module tb_hub75;

    import hub75_pkg::*;

    localparam int W     = DEFAULT_PANEL_WIDTH;
    localparam int H     = DEFAULT_PANEL_HALFHEIGHT;
    localparam int TPB   = DEFAULT_UART_TICKS_PER_BIT;
    localparam int BASE  = DEFAULT_PLANE_BASE_TICKS;
    localparam int STEPS = H * BRIGHTNESS_BITS;  // latches per frame
    localparam int FRAME_CYCLES =
        H * (BRIGHTNESS_BITS * (2 * W + 3) + BASE * ((1 << BRIGHTNESS_BITS) - 1));
    localparam int BYTE_CYCLES = 11 * TPB;       // start, 8 data, stop, idle
    localparam int NUM_BYTES   = 1 + 2 * H * W * 6 + 4 * 2;
    localparam int TIMEOUT_CYCLES =
        NUM_BYTES * BYTE_CYCLES + 5 * 3 * FRAME_CYCLES + 6 * FRAME_CYCLES;

    logic                 clk_root = 1'b0;
    logic                 rst_n;
    logic                 rx;
    logic [2:0]           rgb_top;
    logic [2:0]           rgb_bottom;
    logic [$clog2(H)-1:0] row_address;
    logic                 clk_pixel;
    logic                 row_latch;
    logic                 oe_n;

    pixel_t                     shadow [2*H][W];
    logic [BRIGHTNESS_BITS-1:0] bright_q    = '1;  // copies of the decoder enables
    logic [2:0]                 rgb_en_q    = '1;
    logic [31:0]                lfsr        = 32'd82055;
    logic                       check_on    = 1'b0;
    int                         latch_count = 0;
    int                         col_idx     = 0;
    int                         error_count = 0;
    int                         check_count = 0;

    always #10 clk_root = ~clk_root;

    hub75_top #(
        .PANEL_WIDTH(W),
        .PANEL_HALFHEIGHT(H),
        .UART_TICKS_PER_BIT(TPB),
        .PLANE_BASE_TICKS(BASE)
    ) i_dut (
        .clk_root(clk_root), .rst_n(rst_n), .rx(rx),
        .rgb_top(rgb_top), .rgb_bottom(rgb_bottom), .row_address(row_address),
        .clk_pixel(clk_pixel), .row_latch(row_latch), .oe_n(oe_n)
    );

    // galois lfsr stepped once per bit taken
    function automatic logic [BRIGHTNESS_BITS-1:0] random_channel();
        logic [BRIGHTNESS_BITS-1:0] val;
        int                         i;
        val = '0;
        for (i = 0; i < BRIGHTNESS_BITS; i++) begin
            val  = {val[BRIGHTNESS_BITS-2:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    // shown bit per colour from stored bit p and both enables
    function automatic logic [2:0] expected_bits(input pixel_t px, input int p);
        logic [BRIGHTNESS_BITS-1:0] chan [3];
        logic [2:0]                 shown;
        int                         c;
        chan[0] = px.red;  // colour 0 is red
        chan[1] = px.green;
        chan[2] = px.blue;
        for (c = 0; c < 3; c++) begin
            shown[c] = chan[c][p] & rgb_en_q[c] & bright_q[p];
        end
        return shown;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, b, 1'b0};
        for (i = 0; i < 11; i++) begin
            rx <= (i < 10) ? frame[i] : 1'b1;  // last slot is idle line
            repeat (TPB) @(posedge clk_root);
        end
    endtask

    task automatic write_pixel(input int row, input int col);
        pixel_t px;
        px.red   = random_channel();
        px.green = random_channel();
        px.blue  = random_channel();
        send_byte(CMD_PIXEL);
        send_byte(8'(col));
        send_byte(8'(row));
        send_byte(8'(px.red));
        send_byte(8'(px.green));
        send_byte(8'(px.blue));
        shadow[row][col] = px;
    endtask

    task automatic set_brightness(input logic [7:0] mask);
        send_byte(CMD_BRIGHTNESS);
        send_byte(mask);
        bright_q = mask[BRIGHTNESS_BITS-1:0];
    endtask

    task automatic set_color(input logic [7:0] en);
        send_byte(CMD_COLOR_ENABLE);
        send_byte(en);
        rgb_en_q = en[2:0];
    endtask

    task automatic wait_latches(input int n);
        int target;
        target = latch_count + n;
        while (latch_count < target) @(posedge clk_root);
    endtask

    // settle one full frame before comparing
    task automatic settle_and_check(input int frames);
        check_on <= 1'b0;
        wait_latches(STEPS + 1);
        check_on <= 1'b1;
        wait_latches(frames * STEPS);
        check_on <= 1'b0;
    endtask

    task automatic compare_column(input int step, input int col);
        int         p;
        int         r;
        logic [2:0] exp_top;
        logic [2:0] exp_bottom;
        p          = step % BRIGHTNESS_BITS;
        r          = (step / BRIGHTNESS_BITS) % H;
        exp_top    = expected_bits(shadow[r][col], p);
        exp_bottom = expected_bits(shadow[r + H][col], p);
        check_count++;
        if (rgb_top !== exp_top) begin
            error_count++;
            $display("[ERROR] %0t rgb_top expected %b actual %b (row %0d col %0d plane %0d)",
                     $time, exp_top, rgb_top, r, col, p);
        end
        if (rgb_bottom !== exp_bottom) begin
            error_count++;
            $display("[ERROR] %0t rgb_bottom expected %b actual %b (row %0d col %0d plane %0d)",
                     $time, exp_bottom, rgb_bottom, r + H, col, p);
        end
    endtask

    // panel side monitor
    always @(posedge clk_root) begin
        if (!rst_n) begin
            latch_count <= 0;
            col_idx     <= 0;
        end else if (row_latch) begin
            latch_count <= latch_count + 1;
            col_idx     <= 0;
        end else if (clk_pixel) begin
            col_idx <= col_idx + 1;
            if (check_on && col_idx < W) begin
                compare_column(latch_count, col_idx);
            end else if (check_on) begin
                error_count++;
                $display("clk_pixel pulse beyond the last column at %0t", $time);
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        rx    = 1'b1;
        repeat (3) @(posedge clk_root);
        rst_n <= 1'b1;
        send_byte(8'h7a);  // stray byte ignored by the decoder
        for (int r = 0; r < 2 * H; r++) begin
            for (int c = 0; c < W; c++) begin
                write_pixel(r, c);
            end
        end
        settle_and_check(2);
        set_brightness(8'h05);  // planes 1 and 3 off
        settle_and_check(1);
        set_brightness(8'hff);
        settle_and_check(1);
        set_color(8'h05);       // green off
        settle_and_check(1);
        set_color(8'h07);
        settle_and_check(1);
        $display("pixel errors %0d, assertion failures %0d, pixel checks %0d",
                 error_count, i_dut.u_chk.fail_count, check_count);
        if (check_count == 0) $display("no pixel was compared during the run");
        if (error_count == 0 && i_dut.u_chk.fail_count == 0 && check_count > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_root);
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

// ==== hub75_panel.f ====
source/hub75_pkg.sv
source/uart_rx.sv
source/command_decoder.sv
source/frame_ram.sv
source/scan_timer.sv
source/framebuffer_fetch.sv
source/hub75_top.sv
verification/hub75_chk.sv
verification/tb_hub75.sv
